// File: sprite_scene.f
src/sprite_pkg.sv
src/video_if.sv
src/video_timing.sv
src/frame_ctrl.sv
src/sprite_regs.sv
src/shape_eval.sv
src/pixel_compositor.sv
src/sprite_scene_top.sv
verification/sprite_scene_tb.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --top-module sprite_scene_tb -f sprite_scene.f \
  && ./obj_dir/Vsprite_scene_tb \
  || exit 1

// File: verification/sprite_testdata.txt
# W slot shape x y w h colour | P hcount vcount colour | C commit | F frames to watch
# shape 0 off, 1 block, 2 outline, 3 circle; numbers decimal, colours hex
F 1
W 0 1 4 4 6 5 ff0000
W 1 2 8 6 8 6 00ff00
W 2 3 24 12 4 0 0000ff
P 4 4 ff0000
P 10 8 000000
P 3 4 000000
P 9 6 ff0000
P 12 6 00ff00
P 15 9 00ff00
P 12 9 000000
P 24 12 0000ff
P 27 12 0000ff
P 28 12 000000
C
F 2
W 0 3 6 6 3 0 ffff00
W 1 1 4 4 10 8 00ffff
W 2 0 0 0 0 0 000000
W 3 2 20 14 6 4 ff00ff
F 1
P 6 6 ffff00
P 9 6 00ffff
P 14 11 000000
P 24 12 000000
P 20 14 ff00ff
P 22 16 000000
P 25 16 ff00ff
P 26 17 000000
C
F 2

// File: verification/sprite_scene_tb.sv
`timescale 1ns/1ps

module sprite_scene_tb;
  import sprite_pkg::*;

  logic                 clk_in = 1'b0;
  logic                 rst;
  logic                 wr_en;
  logic [SLOT_BITS-1:0] wr_slot;
  shape_t               wr_shape;
  logic [H_BITS-1:0]    wr_x;
  logic [V_BITS-1:0]    wr_y;
  logic [H_BITS-1:0]    wr_w;
  logic [V_BITS-1:0]    wr_h;
  logic [23:0]          wr_color;
  logic                 commit;
  logic                 commit_pending;
  logic [7:0]           red;
  logic [7:0]           green;
  logic [7:0]           blue;
  logic [H_BITS-1:0]    hcount_out;
  logic [V_BITS-1:0]    vcount_out;
  logic                 hsync;
  logic                 vsync;
  logic                 blank_out;

  // expected colour per probed pixel, keyed by line * 64 + column
  logic [23:0] cur_color [int];
  logic [23:0] nxt_color [int];
  string       cmds [$];
  logic        mon_on = 1'b0;
  int          cycles = 0;
  int          limit = 0;

  // raster position the output should show next
  logic [H_BITS-1:0] exp_h = '0;
  logic [V_BITS-1:0] exp_v = '0;

  sprite_scene_top DUT (.*);

  always #10 clk_in = ~clk_in;

  task automatic check_color(input logic [23:0] got, input logic [23:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s at (%0d,%0d) got %h expected %h",
               $time, what, hcount_out, vcount_out, got, exp);
      $display("Something failed");
      $fatal(1, "colour check");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s at (%0d,%0d) got %b expected %b",
               $time, what, hcount_out, vcount_out, got, exp);
      $display("Something failed");
      $fatal(1, "flag check");
    end
  endtask

  always @(posedge clk_in) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit) begin
      $display("run did not finish within %0d cycles", limit);
      $display("Something failed");
      $fatal(1, "cycle limit");
    end
  end

  // every output pixel against the raster rules and the probe table
  always @(negedge clk_in) begin
    logic exp_blank;
    int   key;
    if (mon_on) begin
      check_flag((hcount_out == exp_h) && (vcount_out == exp_v), 1'b1,
                 "output raster position");
      if (exp_h == H_TOTAL - 11'd1) begin
        exp_h = '0;
        exp_v = (exp_v == V_TOTAL - 10'd1) ? '0 : exp_v + 10'd1;
      end else begin
        exp_h = exp_h + 11'd1;
      end
      exp_blank = (hcount_out >= H_ACTIVE) || (vcount_out >= V_ACTIVE);
      key = int'(vcount_out) * 64 + int'(hcount_out);
      check_flag(blank_out, exp_blank, "blank_out");
      check_flag(hsync, (hcount_out >= H_SYNC_START) && (hcount_out < H_SYNC_END), "hsync");
      check_flag(vsync, (vcount_out >= V_SYNC_START) && (vcount_out < V_SYNC_END), "vsync");
      if (exp_blank) begin
        check_color({red, green, blue}, 24'h0, "rgb in blanking");
      end else if (cur_color.exists(key)) begin
        check_color({red, green, blue}, cur_color[key], "probe colour");
      end
    end
  end

  task automatic wait_pixel(input logic [H_BITS-1:0] h, input logic [V_BITS-1:0] v);
    do begin
      @(negedge clk_in);
    end while (!(hcount_out == h && vcount_out == v));
  endtask

  task automatic run_frames(input int n);
    repeat (n) wait_pixel(11'd0, 10'd0);
  endtask

  task automatic write_slot(input int slot, input int shape, input int x, input int y,
                            input int w, input int h, input logic [23:0] c);
    repeat ($urandom % 4) @(posedge clk_in);
    @(posedge clk_in);
    wr_en    <= 1'b1;
    wr_slot  <= SLOT_BITS'(slot);
    wr_shape <= shape_t'(shape[1:0]);
    wr_x     <= H_BITS'(x);
    wr_y     <= V_BITS'(y);
    wr_w     <= H_BITS'(w);
    wr_h     <= V_BITS'(h);
    wr_color <= c;
    @(posedge clk_in);
    wr_en <= 1'b0;
  endtask

  task automatic commit_scene();
    // early in the frame so the old scene stays visible while pending
    wait_pixel(11'd0, 10'd1);
    @(posedge clk_in);
    commit <= 1'b1;
    @(posedge clk_in);
    commit <= 1'b0;
    @(negedge clk_in);
    check_flag(commit_pending, 1'b1, "commit_pending after commit");
    while (commit_pending) begin
      @(negedge clk_in);
    end
    // copy lands only in vertical blanking
    check_flag(blank_out, 1'b1, "blank_out when copy done");
    // pending ends two pixels into the first blanking line
    check_flag((hcount_out == '0) && (vcount_out == V_ACTIVE), 1'b1,
               "commit_pending end position");
    cur_color.delete();
    foreach (nxt_color[k]) begin
      cur_color[k] = nxt_color[k];
    end
    nxt_color.delete();
  endtask

  initial begin
    int          fd;
    int          commits;
    int          n;
    int          slot;
    int          shape;
    int          x;
    int          y;
    int          w;
    int          h;
    logic [23:0] c;
    string       line;
    void'($urandom(32'hd0e3));
    rst      <= 1'b1;
    wr_en    <= 1'b0;
    wr_slot  <= '0;
    wr_shape <= SHAPE_OFF;
    wr_x     <= '0;
    wr_y     <= '0;
    wr_w     <= '0;
    wr_h     <= '0;
    wr_color <= '0;
    commit   <= 1'b0;
    fd = $fopen("verification/sprite_testdata.txt", "r");
    if (fd == 0) begin
      $display("cannot open the test data file");
      $display("Something failed");
      $fatal(1, "no test data");
    end
    commits = 0;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line.getc(0) != "#") begin
        cmds.push_back(line);
        if (line.getc(0) == "C") begin
          commits++;
        end
      end
    end
    $fclose(fd);
    limit = (commits + 2) * 3 * int'(H_TOTAL) * int'(V_TOTAL);
    // power-up tables are empty, so the whole visible frame is black
    for (int v = 0; v < int'(V_ACTIVE); v++) begin
      for (int k = 0; k < int'(H_ACTIVE); k++) begin
        cur_color[v * 64 + k] = 24'h0;
      end
    end

    repeat (3) @(posedge clk_in);
    rst <= 1'b0;
    @(negedge clk_in);
    check_flag(blank_out, 1'b1, "blank_out after reset");
    check_flag(hsync, 1'b0, "hsync after reset");
    check_flag(vsync, 1'b0, "vsync after reset");
    check_flag(commit_pending, 1'b0, "commit_pending after reset");
    check_color({red, green, blue}, 24'h0, "rgb after reset");
    // pipeline refills with real pixels two edges later
    repeat (2) @(posedge clk_in);
    mon_on = 1'b1;

    foreach (cmds[i]) begin
      line = cmds[i];
      case (line.getc(0))
        "W": begin
          void'($sscanf(line, "W %d %d %d %d %d %d %h", slot, shape, x, y, w, h, c));
          write_slot(slot, shape, x, y, w, h, c);
        end
        "P": begin
          void'($sscanf(line, "P %d %d %h", x, y, c));
          nxt_color[y * 64 + x] = c;
        end
        "C": begin
          commit_scene();
        end
        "F": begin
          void'($sscanf(line, "F %d", n));
          run_frames(n);
        end
        default: begin
          $display("unknown command in the test data: %s", line);
          $display("Something failed");
          $fatal(1, "bad test data");
        end
      endcase
    end
    $display("Everything OK");
    $finish;
  end

endmodule

// File: src/sprite_scene_top.sv
`timescale 1ns/1ps

module sprite_scene_top (
  input  logic                             clk_in,
  input  logic                             rst,
  input  logic                             wr_en,
  input  logic [sprite_pkg::SLOT_BITS-1:0] wr_slot,
  input  sprite_pkg::shape_t               wr_shape,
  input  logic [sprite_pkg::H_BITS-1:0]    wr_x,
  input  logic [sprite_pkg::V_BITS-1:0]    wr_y,
  input  logic [sprite_pkg::H_BITS-1:0]    wr_w,
  input  logic [sprite_pkg::V_BITS-1:0]    wr_h,
  input  logic [23:0]                      wr_color,
  input  logic                             commit,
  output logic                             commit_pending,
  output logic [7:0]                       red,
  output logic [7:0]                       green,
  output logic [7:0]                       blue,
  output logic [sprite_pkg::H_BITS-1:0]    hcount_out,
  output logic [sprite_pkg::V_BITS-1:0]    vcount_out,
  output logic                             hsync,
  output logic                             vsync,
  output logic                             blank_out
);
  import sprite_pkg::*;

  sprite_obj_t                 wr_obj;
  sprite_obj_t [NUM_SLOTS-1:0] active;
  logic                        copy_now;
  logic [NUM_SLOTS-1:0]        hits;
  logic [NUM_SLOTS-1:0][23:0]  colors;

  // raw counter stage and the stage after the hit test
  video_if vid_raw ();
  video_if vid_hit ();

  assign wr_obj = '{shape: wr_shape, x: wr_x, y: wr_y, w: wr_w, h: wr_h, color: wr_color};

  video_timing u_timing (.clk_in(clk_in), .rst(rst), .vid(vid_raw.source));

  frame_ctrl u_ctrl (
    .clk_in(clk_in), .rst(rst), .vid(vid_raw.sink), .commit(commit),
    .copy_now(copy_now), .commit_pending(commit_pending)
  );

  sprite_regs u_regs (
    .clk_in(clk_in), .rst(rst), .wr_en(wr_en), .wr_slot(wr_slot), .wr_obj(wr_obj),
    .copy_now(copy_now), .active(active)
  );

  shape_eval u_eval (
    .clk_in(clk_in), .rst(rst), .vid_in(vid_raw.sink), .vid_out(vid_hit.source),
    .active(active), .hits(hits), .colors(colors)
  );

  pixel_compositor u_comp (
    .clk_in(clk_in), .rst(rst), .vid(vid_hit.sink), .hits(hits), .colors(colors),
    .red(red), .green(green), .blue(blue), .hcount_out(hcount_out),
    .vcount_out(vcount_out), .hsync(hsync), .vsync(vsync), .blank_out(blank_out)
  );

endmodule

// File: src/pixel_compositor.sv
`timescale 1ns/1ps

module pixel_compositor (
  input  logic                                   clk_in,
  input  logic                                   rst,
  video_if.sink                                  vid,
  input  logic [sprite_pkg::NUM_SLOTS-1:0]       hits,
  input  logic [sprite_pkg::NUM_SLOTS-1:0][23:0] colors,
  output logic [7:0]                             red,
  output logic [7:0]                             green,
  output logic [7:0]                             blue,
  output logic [sprite_pkg::H_BITS-1:0]          hcount_out,
  output logic [sprite_pkg::V_BITS-1:0]          vcount_out,
  output logic                                   hsync,
  output logic                                   vsync,
  output logic                                   blank_out
);
  import sprite_pkg::*;

  logic [23:0] pick;

  // walk down so the lowest hitting slot is written last
  always_comb begin
    pick = 24'h00_00_00;
    for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
      if (hits[i]) begin
        pick = colors[i];
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      red        <= '0;
      green      <= '0;
      blue       <= '0;
      hcount_out <= '0;
      vcount_out <= '0;
      hsync      <= 1'b0;
      vsync      <= 1'b0;
      blank_out  <= 1'b1;
    end else begin
      red        <= pick[23:16];
      green      <= pick[15:8];
      blue       <= pick[7:0];
      hcount_out <= vid.hcount;
      vcount_out <= vid.vcount;
      hsync      <= vid.hsync;
      vsync      <= vid.vsync;
      blank_out  <= vid.blank;
    end
  end

endmodule

// File: src/shape_eval.sv
`timescale 1ns/1ps

module shape_eval (
  input  logic                                                clk_in,
  input  logic                                                rst,
  video_if.sink                                               vid_in,
  video_if.source                                             vid_out,
  input  sprite_pkg::sprite_obj_t [sprite_pkg::NUM_SLOTS-1:0] active,
  output logic [sprite_pkg::NUM_SLOTS-1:0]                    hits,
  output logic [sprite_pkg::NUM_SLOTS-1:0][23:0]              colors
);
  import sprite_pkg::*;

  logic [NUM_SLOTS-1:0] hit_next;

  function automatic logic slot_hit(input sprite_obj_t obj,
                                    input logic [H_BITS-1:0] hc,
                                    input logic [V_BITS-1:0] vc);
    logic [H_BITS:0]   x_end;
    logic [V_BITS:0]   y_end;
    logic              in_x;
    logic              in_y;
    logic              on_edge;
    logic [H_BITS-1:0] dx;
    logic [V_BITS-1:0] dy;
    logic [2*H_BITS:0] dist2;
    logic [2*H_BITS:0] rad2;
    logic              hit;

    x_end = {1'b0, obj.x} + {1'b0, obj.w};
    y_end = {1'b0, obj.y} + {1'b0, obj.h};
    in_x  = (hc >= obj.x) && ({1'b0, hc} < x_end);
    in_y  = (vc >= obj.y) && ({1'b0, vc} < y_end);

    // border ring of the rectangle
    on_edge = (hc == obj.x) || ({1'b0, hc} == x_end - 12'd1) ||
              (vc == obj.y) || ({1'b0, vc} == y_end - 11'd1);

    // distance magnitudes, squared at full width
    dx    = (hc >= obj.x) ? hc - obj.x : obj.x - hc;
    dy    = (vc >= obj.y) ? vc - obj.y : obj.y - vc;
    dist2 = {{(H_BITS+1){1'b0}}, dx} * {{(H_BITS+1){1'b0}}, dx} +
            {{(2*H_BITS+1-V_BITS){1'b0}}, dy} * {{(2*H_BITS+1-V_BITS){1'b0}}, dy};
    rad2  = {{(H_BITS+1){1'b0}}, obj.w} * {{(H_BITS+1){1'b0}}, obj.w};

    case (obj.shape)
      SHAPE_BLOCK:   hit = in_x && in_y;
      SHAPE_OUTLINE: hit = in_x && in_y && on_edge;
      SHAPE_CIRCLE:  hit = (dist2 < rad2);
      default:       hit = 1'b0;
    endcase
    return hit;
  endfunction

  always_comb begin
    for (int i = 0; i < NUM_SLOTS; i++) begin
      hit_next[i] = !vid_in.blank && slot_hit(active[i], vid_in.hcount, vid_in.vcount);
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst) begin
      hits <= '0;
    end else begin
      hits <= hit_next;
    end
  end

  // colour sampled alongside the hit
  always_ff @(posedge clk_in) begin
    for (int i = 0; i < NUM_SLOTS; i++) begin
      colors[i] <= active[i].color;
    end
  end

  // video follows the hits by one stage
  always_ff @(posedge clk_in) begin
    if (rst) begin
      vid_out.hcount <= '0;
      vid_out.vcount <= '0;
      vid_out.hsync  <= 1'b0;
      vid_out.vsync  <= 1'b0;
      vid_out.blank  <= 1'b1;
    end else begin
      vid_out.hcount <= vid_in.hcount;
      vid_out.vcount <= vid_in.vcount;
      vid_out.hsync  <= vid_in.hsync;
      vid_out.vsync  <= vid_in.vsync;
      vid_out.blank  <= vid_in.blank;
    end
  end

endmodule

// File: src/sprite_regs.sv
`timescale 1ns/1ps

module sprite_regs (
  input  logic                                          clk_in,
  input  logic                                          rst,
  input  logic                                          wr_en,
  input  logic [sprite_pkg::SLOT_BITS-1:0]              wr_slot,
  input  sprite_pkg::sprite_obj_t                       wr_obj,
  input  logic                                          copy_now,
  output sprite_pkg::sprite_obj_t [sprite_pkg::NUM_SLOTS-1:0] active
);
  import sprite_pkg::*;

  sprite_obj_t [NUM_SLOTS-1:0] shadow;
  sprite_obj_t [NUM_SLOTS-1:0] active_q;

  // host side, shadow only
  always_ff @(posedge clk_in) begin
    if (rst) begin
      for (int i = 0; i < NUM_SLOTS; i++) begin
        shadow[i] <= OBJ_EMPTY;
      end
    end else if (wr_en) begin
      shadow[wr_slot] <= wr_obj;
    end
  end

  // whole table swaps in one edge so the scene never tears
  always_ff @(posedge clk_in) begin
    if (rst) begin
      for (int i = 0; i < NUM_SLOTS; i++) begin
        active_q[i] <= OBJ_EMPTY;
      end
    end else if (copy_now) begin
      active_q <= shadow;
    end
  end

  assign active = active_q;

endmodule

// File: src/frame_ctrl.sv
`timescale 1ns/1ps

module frame_ctrl (
  input  logic  clk_in,
  input  logic  rst,
  video_if.sink vid,
  input  logic  commit,
  output logic  copy_now,
  output logic  commit_pending
);
  import sprite_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_next;
  logic        blank_start;

  // first pixel of the first blanking line
  assign blank_start = (vid.hcount == '0) && (vid.vcount == V_ACTIVE);

  always_ff @(posedge clk_in) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (commit) begin
          state_next = ST_PENDING;
        end
      end
      ST_PENDING: begin
        // extra commits just wait for the same copy
        if (blank_start) begin
          state_next = ST_COPY;
        end
      end
      ST_COPY: begin
        state_next = ST_IDLE;
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  assign copy_now       = (state == ST_COPY);
  assign commit_pending = (state != ST_IDLE);

endmodule

// File: src/video_timing.sv
`timescale 1ns/1ps

module video_timing (
  input  logic   clk_in,
  input  logic   rst,
  video_if.source vid
);
  import sprite_pkg::*;

  logic [H_BITS-1:0] hcount;
  logic [V_BITS-1:0] vcount;
  logic              h_wrap;
  logic              v_wrap;

  assign h_wrap = (hcount == H_TOTAL - 11'd1);
  assign v_wrap = (vcount == V_TOTAL - 10'd1);

  // one pixel per clock
  always_ff @(posedge clk_in) begin
    if (rst) begin
      hcount <= '0;
    end else if (h_wrap) begin
      hcount <= '0;
    end else begin
      hcount <= hcount + 11'd1;
    end
  end

  // line counter steps on each horizontal wrap
  always_ff @(posedge clk_in) begin
    if (rst) begin
      vcount <= '0;
    end else if (h_wrap) begin
      if (v_wrap) begin
        vcount <= '0;
      end else begin
        vcount <= vcount + 10'd1;
      end
    end
  end

  assign vid.hcount = hcount;
  assign vid.vcount = vcount;

  // levels follow the counts in the same cycle
  assign vid.blank = (hcount >= H_ACTIVE) || (vcount >= V_ACTIVE);
  assign vid.hsync = (hcount >= H_SYNC_START) && (hcount < H_SYNC_END);
  assign vid.vsync = (vcount >= V_SYNC_START) && (vcount < V_SYNC_END);

endmodule

// File: src/video_if.sv
`timescale 1ns/1ps

interface video_if;
  import sprite_pkg::*;

  logic [H_BITS-1:0] hcount;
  logic [V_BITS-1:0] vcount;
  logic              hsync;
  logic              vsync;
  logic              blank;

  modport source (
    output hcount,
    output vcount,
    output hsync,
    output vsync,
    output blank
  );

  modport sink (
    input hcount,
    input vcount,
    input hsync,
    input vsync,
    input blank
  );

endinterface

// File: src/sprite_pkg.sv
package sprite_pkg;

  // count widths
  localparam int H_BITS = 11;
  localparam int V_BITS = 10;

  // tiny raster
  localparam logic [H_BITS-1:0] H_ACTIVE     = 11'd32;
  localparam logic [H_BITS-1:0] H_TOTAL      = 11'd40;
  localparam logic [H_BITS-1:0] H_SYNC_START = 11'd34;
  localparam logic [H_BITS-1:0] H_SYNC_END   = 11'd37;

  localparam logic [V_BITS-1:0] V_ACTIVE     = 10'd24;
  localparam logic [V_BITS-1:0] V_TOTAL      = 10'd28;
  localparam logic [V_BITS-1:0] V_SYNC_START = 10'd25;
  localparam logic [V_BITS-1:0] V_SYNC_END   = 10'd26;

  // object table and pipeline
  localparam int NUM_SLOTS  = 4;
  localparam int SLOT_BITS  = 2;
  localparam int PIPE_DEPTH = 2;

  typedef enum logic [1:0] {
    SHAPE_OFF,
    SHAPE_BLOCK,
    SHAPE_OUTLINE,
    SHAPE_CIRCLE
  } shape_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PENDING,
    ST_COPY
  } ctrl_state_t;

  // circle uses x/y as centre and w as radius
  typedef struct packed {
    shape_t              shape;
    logic [H_BITS-1:0]   x;
    logic [V_BITS-1:0]   y;
    logic [H_BITS-1:0]   w;
    logic [V_BITS-1:0]   h;
    logic [23:0]         color;
  } sprite_obj_t;

  localparam sprite_obj_t OBJ_EMPTY = '{shape: SHAPE_OFF, x: '0, y: '0, w: '0, h: '0,
                                        color: '0};

endpackage
